//--- Bender.yml
package:
  name: serial_boot

sources:
  # package first, then the blocks, then the top level
  - files:
      - design/boot_pkg.sv
      - design/boot_byte_fifo.sv
      - design/serial_cfg_shifter.sv
      - design/boot_crc_tracker.sv
      - design/boot_status_arbiter.sv
      - design/serial_boot_top.sv
  - target: test
    files:
      - dv/cfg_target_model.sv
      - dv/serial_boot_tb.sv

//--- design/boot_byte_fifo.sv
`timescale 1ns/1ps

module boot_byte_fifo import boot_pkg::*; #(
  parameter int FIFO_DEPTH = DEFAULT_FIFO_DEPTH
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       start_pulse,
  input  logic       run,
  input  logic [7:0] host_data,
  input  logic       host_valid,
  input  logic       byte_take,
  output logic [7:0] fifo_data,
  output logic       fifo_avail,
  output logic       host_credit
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);

  logic [7:0]       mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [PTR_W-1:0] wr_base;
  logic [PTR_W-1:0] rd_base;
  logic [CNT_W-1:0] cnt_base;
  logic             wr_en;
  logic             rd_en;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == LAST_PTR) ? '0 : p + 1'b1;
  endfunction

  // start pulse empties the buffer, a write in that same cycle still lands
  assign wr_base  = start_pulse ? '0 : wr_ptr;
  assign rd_base  = start_pulse ? '0 : rd_ptr;
  assign cnt_base = start_pulse ? '0 : count;

  // writes outside a run or into a full buffer are dropped
  assign wr_en = run && host_valid && (cnt_base != FULL_CNT);
  assign rd_en = byte_take && !start_pulse && (count != '0);

  assign fifo_data  = mem[rd_ptr];
  assign fifo_avail = (count != '0);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_base] <= host_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      host_credit <= 1'b0;
    end else begin
      // one credit back per byte handed to the shifter
      host_credit <= rd_en;
      wr_ptr      <= wr_en ? ptr_inc(wr_base) : wr_base;
      rd_ptr      <= rd_en ? ptr_inc(rd_base) : rd_base;
      count       <= cnt_base + CNT_W'(wr_en) - CNT_W'(rd_en);
    end
  end

endmodule

//--- design/boot_crc_tracker.sv
`timescale 1ns/1ps

module boot_crc_tracker import boot_pkg::*; #(
  parameter int COUNT_W = DEFAULT_COUNT_W
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               start_pulse,
  input  logic               sent_bit,
  input  logic               bit_strobe,
  output logic [15:0]        crc_value,
  output logic [COUNT_W-1:0] byte_count
);

  logic [15:0] crc_run;
  logic [15:0] crc_next;
  logic [2:0]  bit_cnt;

  // one step of the serial crc register
  function automatic logic [15:0] crc_step(input logic [15:0] crc, input logic din);
    logic fb;
    fb = crc[15] ^ din;
    return {crc[14:0], 1'b0} ^ (fb ? CRC_POLY : 16'h0000);
  endfunction

  assign crc_next = crc_step(crc_run, sent_bit);

  always_ff @(posedge clk) begin
    if (reset) begin
      crc_run    <= CRC_INIT;
      crc_value  <= CRC_INIT;
      bit_cnt    <= 3'd0;
      byte_count <= '0;
    end else if (start_pulse) begin
      crc_run    <= CRC_INIT;
      crc_value  <= CRC_INIT;
      bit_cnt    <= 3'd0;
      byte_count <= '0;
    end else if (bit_strobe) begin
      crc_run <= crc_next;
      bit_cnt <= bit_cnt + 3'd1;
      // published values move only on whole bytes
      if (bit_cnt == 3'd7) begin
        crc_value  <= crc_next;
        byte_count <= byte_count + 1'b1;
      end
    end
  end

endmodule

//--- design/boot_pkg.sv
package boot_pkg;

  // boot state as seen by the host
  typedef enum logic [2:0] {
    STAT_IDLE    = 3'd0,
    STAT_BUSY    = 3'd1,
    STAT_DONE_OK = 3'd2,
    STAT_CRC_ERR = 3'd3,
    STAT_ABORTED = 3'd4
  } boot_status_e;

  // crc-16-ccitt, bits taken in the order they reach the target
  localparam logic [15:0] CRC_POLY = 16'h1021;
  localparam logic [15:0] CRC_INIT = 16'hFFFF;

  // buffer entries, also the number of credits the host starts with
  localparam int DEFAULT_FIFO_DEPTH = 8;

  // byte counter width, wide enough for large bitstreams
  localparam int DEFAULT_COUNT_W = 24;

endpackage

//--- design/boot_status_arbiter.sv
`timescale 1ns/1ps

module boot_status_arbiter import boot_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         boot_start,
  input  logic         abort,
  input  logic         cfg_done,
  input  logic         prog_done,
  input  logic [15:0]  crc_value,
  input  logic [15:0]  expected_crc,
  output logic         run,
  output logic         start_pulse,
  output boot_status_e status
);

  logic done_seen;
  logic crc_ok;

  // done pin only counts once this boot has pulsed prog
  assign done_seen = cfg_done && prog_done;
  assign crc_ok    = (crc_value == expected_crc);

  // run follows the busy state, so it drops with the verdict
  assign run = (status == STAT_BUSY);

  always_ff @(posedge clk) begin
    if (reset) begin
      status      <= STAT_IDLE;
      start_pulse <= 1'b0;
    end else begin
      start_pulse <= 1'b0;
      if (status != STAT_BUSY) begin
        if (boot_start) begin
          status      <= STAT_BUSY;
          start_pulse <= 1'b1;
        end
      end else if (abort) begin
        // abort wins over a done in the same cycle
        status <= STAT_ABORTED;
      end else if (done_seen) begin
        status <= crc_ok ? STAT_DONE_OK : STAT_CRC_ERR;
      end
    end
  end

endmodule

//--- design/serial_boot_top.sv
`timescale 1ns/1ps

module serial_boot_top import boot_pkg::*; #(
  parameter int FIFO_DEPTH = DEFAULT_FIFO_DEPTH,
  parameter int COUNT_W    = DEFAULT_COUNT_W
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               boot_start,
  input  logic               abort,
  input  logic [7:0]         host_data,
  input  logic               host_valid,
  input  logic [15:0]        expected_crc,
  input  logic               cfg_done,
  output logic               host_credit,
  output logic               cfg_prog_n,
  output logic               cfg_cclk,
  output logic               cfg_din,
  output boot_status_e       status,
  output logic [COUNT_W-1:0] byte_count,
  output logic [15:0]        crc_value
);

  logic       run;
  logic       start_pulse;
  logic [7:0] fifo_data;
  logic       fifo_avail;
  logic       byte_take;
  logic       prog_done;
  logic       sent_bit;
  logic       bit_strobe;

  boot_byte_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk(clk), .reset(reset), .start_pulse(start_pulse), .run(run),
    .host_data(host_data), .host_valid(host_valid), .byte_take(byte_take),
    .fifo_data(fifo_data), .fifo_avail(fifo_avail), .host_credit(host_credit)
  );

  serial_cfg_shifter u_shifter (
    .clk(clk), .reset(reset), .start_pulse(start_pulse), .run(run),
    .fifo_data(fifo_data), .fifo_avail(fifo_avail), .byte_take(byte_take),
    .cfg_prog_n(cfg_prog_n), .cfg_cclk(cfg_cclk), .cfg_din(cfg_din),
    .prog_done(prog_done), .sent_bit(sent_bit), .bit_strobe(bit_strobe)
  );

  boot_crc_tracker #(
    .COUNT_W(COUNT_W)
  ) u_tracker (
    .clk(clk), .reset(reset), .start_pulse(start_pulse),
    .sent_bit(sent_bit), .bit_strobe(bit_strobe),
    .crc_value(crc_value), .byte_count(byte_count)
  );

  boot_status_arbiter u_status (
    .clk(clk), .reset(reset), .boot_start(boot_start), .abort(abort),
    .cfg_done(cfg_done), .prog_done(prog_done), .crc_value(crc_value),
    .expected_crc(expected_crc), .run(run), .start_pulse(start_pulse),
    .status(status)
  );

endmodule

//--- design/serial_cfg_shifter.sv
`timescale 1ns/1ps

module serial_cfg_shifter (
  input  logic       clk,
  input  logic       reset,
  input  logic       start_pulse,
  input  logic       run,
  input  logic [7:0] fifo_data,
  input  logic       fifo_avail,
  output logic       byte_take,
  output logic       cfg_prog_n,
  output logic       cfg_cclk,
  output logic       cfg_din,
  output logic       prog_done,
  output logic       sent_bit,
  output logic       bit_strobe
);

  logic       prog_sent;
  logic       busy;
  logic       cclk;
  logic [2:0] bit_idx;
  logic [7:0] shift_byte;
  logic       last_high;

  // high phase of bit 7, the next byte can be fetched now
  assign last_high = busy && cclk && (bit_idx == 3'd7);

  // program pulse in the first run cycle, before prog_sent is set
  assign cfg_prog_n = !(run && !prog_sent);
  assign prog_done  = prog_sent;

  assign byte_take = run && prog_sent && !start_pulse && fifo_avail &&
                     (!busy || last_high);

  assign cfg_cclk = cclk;
  assign cfg_din  = shift_byte[0];
  assign sent_bit = shift_byte[0];

  // low phase cycle whose closing edge raises cclk,
  // so the tracker updates on the same edge the target samples
  assign bit_strobe = run && busy && !cclk;

  always_ff @(posedge clk) begin
    if (reset) begin
      prog_sent <= 1'b0;
      busy      <= 1'b0;
      cclk      <= 1'b0;
      bit_idx   <= 3'd0;
    end else if (!run) begin
      // clock parks low and the next run starts with a fresh program pulse
      prog_sent <= 1'b0;
      busy      <= 1'b0;
      cclk      <= 1'b0;
      bit_idx   <= 3'd0;
    end else begin
      prog_sent <= 1'b1;
      if (start_pulse) begin
        busy    <= 1'b0;
        cclk    <= 1'b0;
        bit_idx <= 3'd0;
      end else if (byte_take) begin
        busy    <= 1'b1;
        cclk    <= 1'b0;
        bit_idx <= 3'd0;
      end else if (busy) begin
        if (cclk) begin
          cclk <= 1'b0;
          if (bit_idx == 3'd7) begin
            // buffer ran dry, hold the clock low
            busy    <= 1'b0;
            bit_idx <= 3'd0;
          end else begin
            bit_idx <= bit_idx + 3'd1;
          end
        end else begin
          cclk <= 1'b1;
        end
      end
    end
  end

  // lsb first, advance once the high phase is over
  always_ff @(posedge clk) begin
    if (byte_take) begin
      shift_byte <= fifo_data;
    end else if (busy && cclk) begin
      shift_byte <= {1'b0, shift_byte[7:1]};
    end
  end

endmodule

//--- dv/cfg_target_model.sv
`timescale 1ns/1ps

module cfg_target_model #(
  parameter int MAX_BYTES = 64
) (
  input  logic        cfg_prog_n,
  input  logic        cfg_cclk,
  input  logic        cfg_din,
  input  logic [15:0] done_after,
  output logic        cfg_done
);

  logic [7:0] cap_mem [MAX_BYTES];
  logic [7:0] shreg;
  logic [7:0] byte_now;
  int         cap_count;
  int         bit_pos;

  initial begin
    cap_count = 0;
    bit_pos   = 0;
    shreg     = 8'h00;
  end

  // prog pulse wipes the capture, cclk rising edge samples din
  always @(negedge cfg_prog_n or posedge cfg_cclk) begin
    if (!cfg_prog_n) begin
      cap_count = 0;
      bit_pos   = 0;
      shreg     = 8'h00;
    end else begin
      // lsb arrives first, so shift in from the top
      byte_now = {cfg_din, shreg[7:1]};
      if (bit_pos == 7) begin
        if (cap_count < MAX_BYTES) begin
          cap_mem[cap_count] = byte_now;
        end
        cap_count = cap_count + 1;
        bit_pos   = 0;
        shreg     = 8'h00;
      end else begin
        shreg   = byte_now;
        bit_pos = bit_pos + 1;
      end
    end
  end

  // done once the expected image size has arrived
  assign cfg_done = (done_after != 16'd0) && (cap_count >= int'(done_after));

endmodule

//--- dv/serial_boot_tb.sv
`timescale 1ns/1ps

module serial_boot_tb
  import boot_pkg::*;
();

  localparam int FIFO_DEPTH   = 8;
  localparam int COUNT_W      = DEFAULT_COUNT_W;
  localparam int CLK_PERIOD   = 100;
  localparam int N_NORMAL     = 20;
  localparam int N_BP         = 32;
  localparam int N_ABORT_PRE  = 8;
  localparam int N_ABORT_POST = 20;
  localparam int N_ABORT_AT   = 5;
  localparam int N_TESTS      = 5;
  localparam int TOTAL_BYTES  = 2 * N_NORMAL + N_BP + N_ABORT_PRE + N_ABORT_POST;
  localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 16 + N_TESTS * 200;
  localparam int WAIT_LIMIT   = 4000;

  logic               clk;
  logic               reset;
  logic               boot_start;
  logic               abort;
  logic [7:0]         host_data;
  logic               host_valid;
  logic [15:0]        expected_crc;
  logic               cfg_done;
  logic               host_credit;
  logic               cfg_prog_n;
  logic               cfg_cclk;
  logic               cfg_din;
  boot_status_e       status;
  logic [COUNT_W-1:0] byte_count;
  logic [15:0]        crc_value;
  logic [15:0]        done_after;

  // host side bookkeeping
  int          credits;
  int          credit_returns;
  int          prog_low_cycles;
  int          seed;
  int unsigned rnd;
  logic [7:0]  tx_q[$];

  serial_boot_top #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .COUNT_W(COUNT_W)
  ) dut0 (
    .clk(clk), .reset(reset), .boot_start(boot_start), .abort(abort),
    .host_data(host_data), .host_valid(host_valid), .expected_crc(expected_crc),
    .cfg_done(cfg_done), .host_credit(host_credit), .cfg_prog_n(cfg_prog_n),
    .cfg_cclk(cfg_cclk), .cfg_din(cfg_din), .status(status),
    .byte_count(byte_count), .crc_value(crc_value)
  );

  cfg_target_model tgt0 (
    .cfg_prog_n(cfg_prog_n), .cfg_cclk(cfg_cclk), .cfg_din(cfg_din),
    .done_after(done_after), .cfg_done(cfg_done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s, got 0x%0h expected 0x%0h", $time, what, got, exp);
      $display("Result: FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting: %s", what);
    $display("Result: FAILED");
    $fatal(1, "wait limit reached");
  endtask

  // count credit returns and prog low cycles at mid cycle
  always @(negedge clk) begin
    if (!reset) begin
      if (host_credit) begin
        credits        = credits + 1;
        credit_returns = credit_returns + 1;
        check_eq(credits <= FIFO_DEPTH, 1, "host credits above buffer depth");
      end
      if (!cfg_prog_n) begin
        prog_low_cycles = prog_low_cycles + 1;
      end
    end
  end

  // reference crc-16-ccitt with the lsb of each byte first
  function automatic logic [15:0] ref_crc();
    logic [15:0] crc;
    logic        fb;
    crc = CRC_INIT;
    foreach (tx_q[i]) begin
      for (int k = 0; k < 8; k++) begin
        fb  = crc[15] ^ tx_q[i][k];
        crc = crc << 1;
        if (fb) begin
          crc = crc ^ CRC_POLY;
        end
      end
    end
    return crc;
  endfunction

  task automatic fill_random(input int n);
    logic [7:0] b;
    tx_q.delete();
    repeat (n) begin
      b = 8'($urandom);
      tx_q.push_back(b);
    end
  endtask

  task automatic start_boot(input logic [15:0] exp_crc, input logic [15:0] done_n);
    @(posedge clk);
    expected_crc    <= exp_crc;
    done_after      <= done_n;
    boot_start      <= 1'b1;
    credits         = FIFO_DEPTH;
    credit_returns  = 0;
    prog_low_cycles = 0;
    @(posedge clk);
    boot_start <= 1'b0;
  endtask

  task automatic put_byte(input logic [7:0] b);
    int guard;
    guard = 0;
    while (credits == 0) begin
      @(posedge clk);
      host_valid <= 1'b0;
      guard++;
      if (guard > WAIT_LIMIT) stop_on_timeout("no host credit returned");
    end
    @(posedge clk);
    host_valid <= 1'b1;
    host_data  <= b;
    credits    = credits - 1;
  endtask

  task automatic check_cclk_parked(input int n);
    repeat (n) begin
      @(negedge clk);
      check_eq(cfg_cclk, 1'b0, "cfg_cclk not held low");
    end
  endtask

  // let the buffer and shifter run dry and then watch the clock
  task automatic drain_pause();
    int guard;
    guard = 0;
    while (credits != FIFO_DEPTH) begin
      @(posedge clk);
      host_valid <= 1'b0;
      guard++;
      if (guard > WAIT_LIMIT) stop_on_timeout("buffer never drained");
    end
    repeat (18) begin
      @(posedge clk);
      host_valid <= 1'b0;
    end
    check_cclk_parked(12);
  endtask

  task automatic send_all(input int gap_max, input int pause_a, input int pause_b);
    foreach (tx_q[i]) begin
      if (i == pause_a || i == pause_b) begin
        drain_pause();
      end else if (gap_max > 0) begin
        repeat ($urandom % (gap_max + 1)) begin
          @(posedge clk);
          host_valid <= 1'b0;
        end
      end
      put_byte(tx_q[i]);
    end
    @(posedge clk);
    host_valid <= 1'b0;
  endtask

  task automatic wait_boot_end();
    int guard;
    guard = 0;
    @(negedge clk);
    while (status == STAT_BUSY) begin
      guard++;
      if (guard > WAIT_LIMIT) stop_on_timeout("boot never left BUSY");
      @(negedge clk);
    end
  endtask

  task automatic check_capture();
    check_eq(tgt0.cap_count, tx_q.size(), "captured byte count");
    foreach (tx_q[i]) begin
      check_eq(tgt0.cap_mem[i], tx_q[i], $sformatf("captured byte %0d", i));
    end
  endtask

  task automatic check_reset_state();
    @(negedge clk);
    check_eq(status, STAT_IDLE, "status after reset");
    check_eq(cfg_prog_n, 1'b1, "cfg_prog_n after reset");
    check_eq(cfg_cclk, 1'b0, "cfg_cclk after reset");
    check_eq(host_credit, 1'b0, "host_credit after reset");
    // writes before any boot_start must be dropped silently
    repeat (4) begin
      @(posedge clk);
      host_valid <= 1'b1;
      host_data  <= 8'($urandom);
    end
    @(posedge clk);
    host_valid <= 1'b0;
    repeat (6) @(negedge clk);
    check_eq(credit_returns, 0, "credit returned while idle");
    check_eq(status, STAT_IDLE, "status after idle writes");
  endtask

  task automatic normal_boot();
    fill_random(N_NORMAL);
    start_boot(ref_crc(), N_NORMAL);
    send_all(0, -1, -1);
    wait_boot_end();
    check_eq(prog_low_cycles, 1, "cfg_prog_n low cycles");
    check_capture();
    check_eq(byte_count, N_NORMAL, "byte_count after boot");
    check_eq(crc_value, ref_crc(), "crc_value after boot");
    check_eq(status, STAT_DONE_OK, "status with correct crc");
    check_eq(credit_returns, N_NORMAL, "credits returned");
  endtask

  task automatic crc_mismatch_boot();
    // same image as before with a wrong expected crc
    start_boot(ref_crc() ^ 16'h8001, N_NORMAL);
    send_all(0, -1, -1);
    wait_boot_end();
    check_eq(status, STAT_CRC_ERR, "status with wrong crc");
    check_capture();
    check_eq(crc_value, ref_crc(), "crc_value on mismatch");
  endtask

  task automatic credit_backpressure();
    fill_random(N_BP);
    start_boot(ref_crc(), N_BP);
    send_all(3, 10, 22);
    wait_boot_end();
    check_eq(status, STAT_DONE_OK, "status after gapped stream");
    check_capture();
    check_eq(byte_count, N_BP, "byte_count after gapped stream");
    check_eq(credit_returns, N_BP, "one credit per byte");
    check_eq(credits, FIFO_DEPTH, "all credits back");
  endtask

  task automatic abort_and_restart();
    int guard;
    guard = 0;
    fill_random(N_ABORT_PRE);
    start_boot(16'h0000, 16'hFFFF);
    send_all(0, -1, -1);
    @(negedge clk);
    while (tgt0.cap_count < N_ABORT_AT) begin
      guard++;
      if (guard > WAIT_LIMIT) stop_on_timeout("five bytes never captured");
      @(negedge clk);
    end
    @(posedge clk);
    abort <= 1'b1;
    @(posedge clk);
    abort <= 1'b0;
    @(negedge clk);
    check_eq(status, STAT_ABORTED, "status after abort");
    // the sixth byte is still mid flight when abort lands
    check_eq(byte_count, N_ABORT_AT, "byte_count at abort");
    check_cclk_parked(20);
    check_eq(byte_count, N_ABORT_AT, "byte_count frozen after abort");

    // fresh boot after the abort
    fill_random(N_ABORT_POST);
    start_boot(ref_crc(), N_ABORT_POST);
    repeat (2) @(negedge clk);
    check_eq(byte_count, 0, "byte_count restart");
    send_all(0, -1, -1);
    wait_boot_end();
    check_eq(prog_low_cycles, 1, "program pulse on restart");
    check_eq(status, STAT_DONE_OK, "status after restart");
    check_capture();
    check_eq(byte_count, N_ABORT_POST, "byte_count after restart");
    check_eq(credit_returns, N_ABORT_POST, "credits after restart");
  endtask

  initial begin
    reset           <= 1'b1;
    boot_start      <= 1'b0;
    abort           <= 1'b0;
    host_data       <= 8'h00;
    host_valid      <= 1'b0;
    expected_crc    <= 16'h0000;
    done_after      <= 16'd0;
    credits         = 0;
    credit_returns  = 0;
    prog_low_cycles = 0;
    seed            = 95011;
    rnd             = $urandom(seed);
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    check_reset_state();
    normal_boot();
    crc_mismatch_boot();
    credit_backpressure();
    abort_and_restart();

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- src.f
design/boot_pkg.sv
design/boot_byte_fifo.sv
design/serial_cfg_shifter.sv
design/boot_crc_tracker.sv
design/boot_status_arbiter.sv
design/serial_boot_top.sv
dv/cfg_target_model.sv
dv/serial_boot_tb.sv
